//--- hw/morse_key_pkg.sv
`default_nettype none

package morse_key_pkg;

    // ------------------------------
    // key packet fields
    // ------------------------------
    typedef logic [2:0] pkt_type_t;   // event class
    typedef logic [7:0] key_code_t;   // symbol within class

    // type field sits above the key code
    typedef logic [$bits(pkt_type_t)+$bits(key_code_t)-1:0] key_packet_t;

    // ------------------------------
    // encodings
    // ------------------------------
    localparam pkt_type_t TYPE_KEY = 3'd1;   // key event

    localparam key_code_t KEY_DOT  = 8'd1;
    localparam key_code_t KEY_DASH = 8'd2;

endpackage

`default_nettype wire

//--- hw/morse_timing_pkg.sv
`default_nettype none

package morse_timing_pkg;

    // durations and thresholds in clk cycles
    typedef logic [31:0] cycle_count_t;

    // ------------------------------
    // button vector layout
    // ------------------------------
    localparam int NUM_BUTTONS = 2;
    localparam int BTN_KEY     = 0;   // dot/dash key
    localparam int BTN_REPEAT  = 1;   // auto dot button

    typedef logic [NUM_BUTTONS-1:0] btn_vec_t;

    // auto repeat FSM
    typedef enum logic [1:0] {
        AR_IDLE,
        AR_DELAY,     // waiting out hold delay
        AR_REPEAT     // emitting dots every interval
    } ar_state_t;

endpackage

`default_nettype wire

//--- hw/button_sync.sv
`timescale 1ns/1ps
`default_nettype none

module button_sync
    import morse_timing_pkg::*;
(
    input  wire      clk,
    input  wire      rst_n,
    input  btn_vec_t btn,
    output btn_vec_t btn_synced
);

    btn_vec_t meta;   // first stage may go metastable

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta       <= '0;
            btn_synced <= '0;
        end else begin
            meta       <= btn;
            btn_synced <= meta;
        end
    end

endmodule

`default_nettype wire

//--- hw/button_debounce.sv
`timescale 1ns/1ps
`default_nettype none

module button_debounce
    import morse_timing_pkg::*;
#(
    parameter cycle_count_t DEBOUNCE_CYCLES = 32'd50_000
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  raw,
    output logic stable
);

    cycle_count_t count;   // cycles raw has disagreed with stable

    // ------------------------------
    // accept new level after a steady run
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stable <= 1'b0;
            count  <= '0;
        end else begin
            if (raw != stable) begin
                if (count >= DEBOUNCE_CYCLES) begin
                    stable <= raw;
                    count  <= '0;
                end else begin
                    count <= count + 1'b1;
                end
            end else begin
                count <= '0;   // bounced back so start over
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/auto_repeat.sv
`timescale 1ns/1ps
`default_nettype none

module auto_repeat
    import morse_timing_pkg::*;
#(
    parameter cycle_count_t AUTOREPEAT_DELAY_CYCLES    = 32'd5_000_000,
    parameter cycle_count_t AUTOREPEAT_INTERVAL_CYCLES = 32'd1_000_000
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  held,
    output logic auto_dot_pulse
);

    ar_state_t    state;
    cycle_count_t count;
    logic         held_prev;
    logic         held_rise;

    assign held_rise = held && !held_prev;

    // ------------------------------
    // hold delay then periodic dots
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= AR_IDLE;
            count          <= '0;
            held_prev      <= 1'b0;
            auto_dot_pulse <= 1'b0;
        end else begin
            held_prev      <= held;
            auto_dot_pulse <= 1'b0;

            case (state)
                AR_IDLE: begin
                    if (held_rise) begin
                        state <= AR_DELAY;
                        count <= '0;
                    end
                end

                AR_DELAY: begin
                    if (!held) begin
                        state <= AR_IDLE;   // released before first dot
                    end else if (count >= AUTOREPEAT_DELAY_CYCLES) begin
                        auto_dot_pulse <= 1'b1;
                        state          <= AR_REPEAT;
                        count          <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end

                AR_REPEAT: begin
                    if (!held) begin
                        state <= AR_IDLE;
                    end else if (count >= AUTOREPEAT_INTERVAL_CYCLES) begin
                        auto_dot_pulse <= 1'b1;
                        count          <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end

                default: state <= AR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/morse_keyer.sv
`timescale 1ns/1ps
`default_nettype none

module morse_keyer
    import morse_timing_pkg::*;
    import morse_key_pkg::*;
#(
    parameter cycle_count_t DEBOUNCE_CYCLES            = 32'd50_000,
    parameter cycle_count_t LONG_PRESS_CYCLES          = 32'd2_500_000,
    parameter cycle_count_t AUTOREPEAT_DELAY_CYCLES    = 32'd5_000_000,
    parameter cycle_count_t AUTOREPEAT_INTERVAL_CYCLES = 32'd1_000_000
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         key_level,
    input  wire         repeat_level,
    output logic        dot_pulse,
    output logic        dash_pulse,
    output logic        auto_dot_pulse,
    output logic        key_valid,
    output key_packet_t key_packet
);

    logic         key_prev;
    logic         key_rise;
    logic         key_fall;
    cycle_count_t press_len;   // saturating

    assign key_rise = key_level && !key_prev;
    assign key_fall = !key_level && key_prev;

    // ------------------------------
    // press length and classification
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_prev   <= 1'b0;
            press_len  <= '0;
            dot_pulse  <= 1'b0;
            dash_pulse <= 1'b0;
        end else begin
            key_prev   <= key_level;
            dot_pulse  <= 1'b0;
            dash_pulse <= 1'b0;

            if (key_rise) begin
                press_len <= '0;
            end else if (key_level && press_len != '1) begin
                press_len <= press_len + 1'b1;
            end

            // short presses below debounce time are dropped
            if (key_fall) begin
                if (press_len >= LONG_PRESS_CYCLES) begin
                    dash_pulse <= 1'b1;
                end else if (press_len > DEBOUNCE_CYCLES) begin
                    dot_pulse <= 1'b1;
                end
            end
        end
    end

    auto_repeat #(
        .AUTOREPEAT_DELAY_CYCLES    (AUTOREPEAT_DELAY_CYCLES),
        .AUTOREPEAT_INTERVAL_CYCLES (AUTOREPEAT_INTERVAL_CYCLES)
    ) u_auto_repeat (
        .clk            (clk),
        .rst_n          (rst_n),
        .held           (repeat_level),
        .auto_dot_pulse (auto_dot_pulse)
    );

    // ------------------------------
    // packet builder
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_valid  <= 1'b0;
            key_packet <= '0;
        end else begin
            key_valid <= 1'b0;
            if (dash_pulse) begin   // dash wins a tie
                key_valid  <= 1'b1;
                key_packet <= {TYPE_KEY, KEY_DASH};
            end else if (dot_pulse || auto_dot_pulse) begin
                key_valid  <= 1'b1;
                key_packet <= {TYPE_KEY, KEY_DOT};
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/morse_button_input.sv
`timescale 1ns/1ps
`default_nettype none

module morse_button_input
    import morse_timing_pkg::*;
    import morse_key_pkg::*;
#(
    parameter cycle_count_t DEBOUNCE_CYCLES            = 32'd50_000,
    parameter cycle_count_t LONG_PRESS_CYCLES          = 32'd2_500_000,
    parameter cycle_count_t AUTOREPEAT_DELAY_CYCLES    = 32'd5_000_000,
    parameter cycle_count_t AUTOREPEAT_INTERVAL_CYCLES = 32'd1_000_000
) (
    input  wire         clk,
    input  wire         rst_n,
    input  btn_vec_t    btn,
    output key_packet_t key_packet,
    output logic        key_valid,
    output logic        dot_pulse,
    output logic        dash_pulse,
    output logic        auto_dot_pulse,
    output logic        key_held
);

    btn_vec_t btn_synced;
    btn_vec_t btn_stable;

    button_sync u_sync (
        .clk        (clk),
        .rst_n      (rst_n),
        .btn        (btn),
        .btn_synced (btn_synced)
    );

    // one debouncer per button
    for (genvar i = 0; i < NUM_BUTTONS; i++) begin : g_debounce
        button_debounce #(
            .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
        ) u_debounce (
            .clk    (clk),
            .rst_n  (rst_n),
            .raw    (btn_synced[i]),
            .stable (btn_stable[i])
        );
    end

    morse_keyer #(
        .DEBOUNCE_CYCLES            (DEBOUNCE_CYCLES),
        .LONG_PRESS_CYCLES          (LONG_PRESS_CYCLES),
        .AUTOREPEAT_DELAY_CYCLES    (AUTOREPEAT_DELAY_CYCLES),
        .AUTOREPEAT_INTERVAL_CYCLES (AUTOREPEAT_INTERVAL_CYCLES)
    ) u_keyer (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_level      (btn_stable[BTN_KEY]),
        .repeat_level   (btn_stable[BTN_REPEAT]),
        .dot_pulse      (dot_pulse),
        .dash_pulse     (dash_pulse),
        .auto_dot_pulse (auto_dot_pulse),
        .key_valid      (key_valid),
        .key_packet     (key_packet)
    );

    assign key_held = btn_stable[BTN_KEY];   // debounced key level

endmodule

`default_nettype wire

//--- sim/tb_morse_pkg.sv
`default_nettype none

package tb_morse_pkg;

    import morse_timing_pkg::*;

    // ------------------------------
    // short DUT timing
    // ------------------------------
    localparam cycle_count_t DEBOUNCE_CYCLES            = 32'd4;
    localparam cycle_count_t LONG_PRESS_CYCLES          = 32'd40;
    localparam cycle_count_t AUTOREPEAT_DELAY_CYCLES    = 32'd60;
    localparam cycle_count_t AUTOREPEAT_INTERVAL_CYCLES = 32'd20;

    localparam btn_vec_t KEY_MASK    = 2'b01;   // btn 0
    localparam btn_vec_t REPEAT_MASK = 2'b10;   // btn 1

    localparam cycle_count_t PRESS_MARGIN  = 32'd8;    // random presses stay this far off thresholds
    localparam cycle_count_t HELD_CHECK_AT = 32'd12;   // press cycle where key_held is sampled

    localparam int QUIET_CYCLES = 16;   // outputs idle this long means done
    localparam int IDLE_TIMEOUT = 400;
    localparam int NUM_RANDOM   = 6;

    localparam int unsigned LCG_SEED = 48;

    // ------------------------------
    // stimulus table
    // ------------------------------
    typedef struct packed {
        btn_vec_t     btn_mask;     // one-hot button
        cycle_count_t hold;         // steady press after the bounce
        logic [15:0]  bounce;       // one bit per cycle from the lsb
        cycle_count_t bounce_len;
        cycle_count_t exp_dots;     // key dots or auto dots
        cycle_count_t exp_dashes;
    } stim_row_t;

    localparam int NUM_ROWS = 8;

    // first auto dot at delay+2 then one every interval+1 cycles
    localparam stim_row_t STIM_TABLE [NUM_ROWS] = '{
        '{KEY_MASK,    32'd20,  16'h0000, 32'd0,  32'd1, 32'd0},   // short press
        '{KEY_MASK,    32'd80,  16'h0000, 32'd0,  32'd0, 32'd1},   // long press
        '{KEY_MASK,    32'd3,   16'h0000, 32'd0,  32'd0, 32'd0},   // too short
        '{KEY_MASK,    32'd0,   16'h0067, 32'd8,  32'd0, 32'd0},   // bounce only
        '{KEY_MASK,    32'd20,  16'h0567, 32'd12, 32'd1, 32'd0},   // bounce then dot
        '{REPEAT_MASK, 32'd150, 16'h0000, 32'd0,  32'd5, 32'd0},
        '{REPEAT_MASK, 32'd100, 16'h0000, 32'd0,  32'd2, 32'd0},
        '{REPEAT_MASK, 32'd40,  16'h0000, 32'd0,  32'd0, 32'd0}    // released in the delay
    };

    // ------------------------------
    // random press lengths
    // ------------------------------
    function automatic int unsigned lcg_next(int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic bit near_threshold(cycle_count_t hold);
        return hold <= DEBOUNCE_CYCLES + PRESS_MARGIN
            || (hold + PRESS_MARGIN > LONG_PRESS_CYCLES
                && hold < LONG_PRESS_CYCLES + PRESS_MARGIN);
    endfunction

endpackage

`default_nettype wire

//--- sim/tb_morse_button_input.sv
`timescale 1ns/1ps
`default_nettype none

module tb_morse_button_input
    import morse_timing_pkg::*;
    import morse_key_pkg::*;
    import tb_morse_pkg::*;
();

    logic        clk = 1'b0;
    logic        rst_n;
    btn_vec_t    btn;
    key_packet_t key_packet;
    logic        key_valid;
    logic        dot_pulse;
    logic        dash_pulse;
    logic        auto_dot_pulse;
    logic        key_held;

    int          errors = 0;
    int          tests = 0;
    int unsigned lcg_state;

    // monitor state
    cycle_count_t dot_seen = '0;
    cycle_count_t dash_seen = '0;
    cycle_count_t missing_seen = '0;
    cycle_count_t dot_pulses = '0;
    cycle_count_t dash_pulses = '0;
    cycle_count_t auto_pulses = '0;
    key_packet_t  last_packet = '0;
    logic         pulse_prev = 1'b0;

    always #20 clk = ~clk;

    morse_button_input #(
        .DEBOUNCE_CYCLES            (DEBOUNCE_CYCLES),
        .LONG_PRESS_CYCLES          (LONG_PRESS_CYCLES),
        .AUTOREPEAT_DELAY_CYCLES    (AUTOREPEAT_DELAY_CYCLES),
        .AUTOREPEAT_INTERVAL_CYCLES (AUTOREPEAT_INTERVAL_CYCLES)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .btn            (btn),
        .key_packet     (key_packet),
        .key_valid      (key_valid),
        .dot_pulse      (dot_pulse),
        .dash_pulse     (dash_pulse),
        .auto_dot_pulse (auto_dot_pulse),
        .key_held       (key_held)
    );

    // ------------------------------
    // monitor samples at negedge
    // ------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (pulse_prev && !key_valid) begin
                $display("no key_valid strobe after a pulse at %0t", $time);
                missing_seen = missing_seen + 1;
            end
            if (key_valid) begin
                last_packet = key_packet;
                if (key_packet[7:0] == KEY_DASH) dash_seen = dash_seen + 1;
                else dot_seen = dot_seen + 1;
            end
            if (dot_pulse) dot_pulses = dot_pulses + 1;
            if (dash_pulse) dash_pulses = dash_pulses + 1;
            if (auto_dot_pulse) auto_pulses = auto_pulses + 1;
            pulse_prev = dot_pulse || dash_pulse || auto_dot_pulse;
        end
    end

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_packet(input string name, input key_packet_t got, input key_packet_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input cycle_count_t got,
                               input cycle_count_t exp, input cycle_count_t tol);
        if (got + tol < exp || got > exp + tol) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_tick();
        @(posedge clk);
        #2;
    endtask

    task automatic press_button(input stim_row_t row);
        logic [15:0] pat;
        pat = row.bounce;
        for (cycle_count_t c = '0; c < row.bounce_len; c++) begin
            drive_tick();
            btn = pat[0] ? row.btn_mask : '0;
            pat = pat >> 1;
        end
        for (cycle_count_t c = '0; c < row.hold; c++) begin
            drive_tick();
            btn = row.btn_mask;
            if (row.btn_mask == KEY_MASK && c == HELD_CHECK_AT
                    && row.hold > HELD_CHECK_AT + 4) begin
                @(negedge clk);
                check_level("key_held", key_held, 1'b1);
            end
        end
        drive_tick();
        btn = '0;
    endtask

    task automatic wait_idle(input int test_no);
        int quiet;
        int cycles;
        quiet = 0;
        cycles = 0;
        while (quiet < QUIET_CYCLES && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (key_valid || dot_pulse || dash_pulse || auto_dot_pulse || key_held) quiet = 0;
            else quiet++;
        end
        if (quiet < QUIET_CYCLES) begin
            $display("test %0d timed out waiting for the DUT to go idle", test_no);
            errors++;
        end
    endtask

    task automatic run_test(input int test_no, input stim_row_t row);
        cycle_count_t dots0;
        cycle_count_t dashes0;
        cycle_count_t missing0;
        cycle_count_t dot_pulses0;
        cycle_count_t dash_pulses0;
        cycle_count_t auto_pulses0;
        cycle_count_t exp_key_dots;
        cycle_count_t exp_auto_dots;
        cycle_count_t tol;
        int           errors0;
        dots0 = dot_seen;
        dashes0 = dash_seen;
        missing0 = missing_seen;
        dot_pulses0 = dot_pulses;
        dash_pulses0 = dash_pulses;
        auto_pulses0 = auto_pulses;
        errors0 = errors;
        press_button(row);
        wait_idle(test_no);
        tol = (row.btn_mask == REPEAT_MASK) ? 32'd1 : 32'd0;   // sync and debounce skew
        exp_key_dots = (row.btn_mask == KEY_MASK) ? row.exp_dots : 32'd0;
        exp_auto_dots = (row.btn_mask == REPEAT_MASK) ? row.exp_dots : 32'd0;
        check_count("dot packets", dot_seen - dots0, row.exp_dots, tol);
        check_count("dash packets", dash_seen - dashes0, row.exp_dashes, 32'd0);
        check_count("missing packets", missing_seen - missing0, 32'd0, 32'd0);
        check_count("dot_pulse", dot_pulses - dot_pulses0, exp_key_dots, 32'd0);
        check_count("dash_pulse", dash_pulses - dash_pulses0, row.exp_dashes, 32'd0);
        check_count("auto_dot_pulse", auto_pulses - auto_pulses0, exp_auto_dots, tol);
        if (row.exp_dashes != '0) check_packet("key_packet", last_packet, {TYPE_KEY, KEY_DASH});
        else if (row.exp_dots != '0) check_packet("key_packet", last_packet, {TYPE_KEY, KEY_DOT});
        $display("test %0d: btn %b hold %0d, %0d dots %0d dashes, %s", test_no, row.btn_mask,
                 row.hold, dot_seen - dots0, dash_seen - dashes0,
                 (errors == errors0) ? "ok" : "error");
        tests++;
    endtask

    task automatic random_press_len(output cycle_count_t hold);
        cycle_count_t cand;
        hold = 32'd20;
        for (int t = 0; t < 100; t++) begin
            lcg_state = lcg_next(lcg_state);
            cand = cycle_count_t'((lcg_state >> 16) % 100) + 32'd1;
            if (!near_threshold(cand)) begin
                hold = cand;
                break;
            end
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        stim_row_t    row;
        cycle_count_t hold;
        int           errors0;
        btn = '0;
        rst_n = 1'b0;
        lcg_state = LCG_SEED;
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;

        @(negedge clk);
        errors0 = errors;
        check_packet("key_packet", key_packet, '0);
        check_level("key_valid", key_valid, 1'b0);
        check_level("dot_pulse", dot_pulse, 1'b0);
        check_level("dash_pulse", dash_pulse, 1'b0);
        check_level("auto_dot_pulse", auto_dot_pulse, 1'b0);
        check_level("key_held", key_held, 1'b0);
        $display("test 0: reset values, %s", (errors == errors0) ? "ok" : "error");
        tests++;

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_test(tests, STIM_TABLE[r[2:0]]);
        end

        // stable level stays high for hold cycles so press_len ends at hold-1
        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_press_len(hold);
            row.btn_mask = KEY_MASK;
            row.hold = hold;
            row.bounce = '0;
            row.bounce_len = '0;
            row.exp_dashes = (hold - 1 >= LONG_PRESS_CYCLES) ? 32'd1 : 32'd0;
            row.exp_dots = (hold - 1 < LONG_PRESS_CYCLES && hold - 1 > DEBOUNCE_CYCLES)
                           ? 32'd1 : 32'd0;
            run_test(tests, row);
        end

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hw/morse_key_pkg.sv
hw/morse_timing_pkg.sv
hw/button_sync.sv
hw/button_debounce.sv
hw/auto_repeat.sv
hw/morse_keyer.sv
hw/morse_button_input.sv
sim/tb_morse_pkg.sv
sim/tb_morse_button_input.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_morse_button_input -Mdir obj_dir

out=$(./obj_dir/Vtb_morse_button_input)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1
